/* Bender.yml */
package:
  name: exec_slice

sources:
  - include_dirs:
      - .
    files:
      - exec_pkg.sv
      - issue_if.sv
      - wb_if.sv
      - reg_file.sv
      - insn_decode.sv
      - alu_execute.sv
      - result_commit.sv
      - exec_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_exec_top.sv

/* alu_execute.sv */
// skipped instructions still carry the alu result on data with wen low
`timescale 1ns/1ps
`include "exec_cfg.svh"

module alu_execute import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  issue_if.execute iss,
  wb_if.execute    wb
);

  localparam int SH_W = $clog2(`DATA_W);

  logic [`DATA_W-1:0] a_fwd;
  logic [`DATA_W-1:0] b_fwd;
  flags_t             fl_fwd;
  flags_t             fl_new;
  logic [`DATA_W-1:0] b_eff;
  logic [`DATA_W:0]   sum;
  logic [`DATA_W-1:0] res;
  logic [SH_W-1:0]    shamt;
  logic               sub_op;
  logic               arith;
  logic               do_flags;
  logic               do_wr;

  function automatic logic cond_true(cond_t cc, flags_t f);
    case (cc)
      cc_eq: return f.z;
      cc_ne: return !f.z;
      cc_cs: return f.c;
      cc_cc: return !f.c;
      cc_mi: return f.n;
      cc_pl: return !f.n;
      cc_vs: return f.v;
      cc_vc: return !f.v;
      cc_hi: return f.c && !f.z;
      cc_ls: return !f.c || f.z;
      cc_ge: return f.n == f.v;
      cc_lt: return f.n != f.v;
      cc_gt: return !f.z && f.n == f.v;
      cc_le: return f.z || f.n != f.v;
      cc_al: return 1'b1;
      cc_nv: return 1'b0;
    endcase
  endfunction

  // newest producer wins, execute register before result register
  always_comb begin
    a_fwd  = iss.a_val;
    b_fwd  = iss.b_val;
    fl_fwd = iss.flags;
    if (wb.wen && wb.rd == iss.ra) a_fwd = wb.data;
    else if (wb.wr_en && wb.wr_rd == iss.ra) a_fwd = wb.wr_data;
    if (wb.wen && wb.rd == iss.rb) b_fwd = wb.data;
    else if (wb.wr_en && wb.wr_rd == iss.rb) b_fwd = wb.wr_data;
    if (wb.fwen) fl_fwd = wb.flags;
    else if (wb.wr_flags_en) fl_fwd = wb.wr_flags;
  end

  always_comb begin
    sub_op = iss.op inside {op_sub, op_cmp};
    arith  = iss.op inside {op_add, op_sub, op_addi, op_cmp};
    b_eff  = (iss.op == op_addi) ? iss.imm : b_fwd;
    if (sub_op) b_eff = ~b_fwd;            // a + ~b + 1
    sum    = {1'b0, a_fwd} + {1'b0, b_eff} + {{`DATA_W{1'b0}}, sub_op};
    shamt  = iss.imm[SH_W-1:0];

    case (iss.op)
      op_add, op_sub, op_addi, op_cmp: res = sum[`DATA_W-1:0];
      op_and:   res = a_fwd & b_fwd;
      op_or:    res = a_fwd | b_fwd;
      op_xor:   res = a_fwd ^ b_fwd;
      op_shl:   res = a_fwd << shamt;
      op_shr:   res = a_fwd >> shamt;
      op_sar:   res = $signed(a_fwd) >>> shamt;
      op_movi:  res = iss.imm;
      op_sxtb:  res = {{(`DATA_W-8){a_fwd[7]}}, a_fwd[7:0]};
      op_sxth:  res = {{(`DATA_W-16){a_fwd[15]}}, a_fwd[15:0]};
      op_bswap: res = {a_fwd[7:0], a_fwd[15:8], a_fwd[23:16], a_fwd[31:24]};
      default:  res = a_fwd;               // nops
    endcase

    fl_new   = fl_fwd;                     // c and v kept unless arith
    fl_new.n = res[`DATA_W-1];
    fl_new.z = (res == '0);
    if (arith) begin
      fl_new.c = sum[`DATA_W];
      fl_new.v = (a_fwd[`DATA_W-1] == b_eff[`DATA_W-1]) &&
                 (res[`DATA_W-1] != a_fwd[`DATA_W-1]);
    end

    do_flags = iss.valid && cond_true(iss.cond, fl_fwd) &&
               !(iss.op inside {op_nop_e, op_nop_f});
    do_wr    = do_flags && iss.op != op_cmp;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb.valid <= 1'b0;
      wb.wen   <= 1'b0;
      wb.fwen  <= 1'b0;
    end else begin
      wb.valid <= iss.valid;
      wb.wen   <= do_wr;
      wb.fwen  <= do_flags;
    end
  end

  always_ff @(posedge clk) begin
    wb.rd    <= iss.rd;
    wb.data  <= res;
    wb.flags <= do_flags ? fl_new : fl_fwd;  // unchanged flags reported on skip
  end

  a_en_valid: assert property (@(posedge clk) disable iff (rst)
    (wb.wen || wb.fwen) |-> wb.valid);

endmodule

/* exec_cfg.svh */
// sizes are fixed for a 32-bit slice and the byte swap assumes a 4-byte word
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

`define DATA_W   32  // one word
`define REG_CNT  16
`define REG_AW   4
`define INSN_W   32

// msb of each instruction field
`define OP_MSB   31
`define COND_MSB 27
`define RD_MSB   23
`define RA_MSB   19
`define RB_MSB   15

// alu immediate width
// movi takes bits RB_MSB down to 0 instead
`define IMM_W    12

`endif

/* exec_pkg.sv */
// opcode and condition fields are both 4 bits wide and every code is defined
package exec_pkg;

  typedef enum logic [3:0] {
    op_add   = 4'd0,
    op_sub   = 4'd1,
    op_addi  = 4'd2,
    op_cmp   = 4'd3,   // flags only
    op_and   = 4'd4,
    op_or    = 4'd5,
    op_xor   = 4'd6,
    op_shl   = 4'd7,
    op_shr   = 4'd8,
    op_sar   = 4'd9,
    op_movi  = 4'd10,
    op_sxtb  = 4'd11,
    op_sxth  = 4'd12,
    op_bswap = 4'd13,
    op_nop_e = 4'd14,
    op_nop_f = 4'd15
  } op_t;

  // tested on the flags in force before the instruction
  typedef enum logic [3:0] {
    cc_eq = 4'd0,
    cc_ne = 4'd1,
    cc_cs = 4'd2,
    cc_cc = 4'd3,
    cc_mi = 4'd4,
    cc_pl = 4'd5,
    cc_vs = 4'd6,
    cc_vc = 4'd7,
    cc_hi = 4'd8,   // unsigned higher
    cc_ls = 4'd9,
    cc_ge = 4'd10,  // signed
    cc_lt = 4'd11,
    cc_gt = 4'd12,
    cc_le = 4'd13,
    cc_al = 4'd14,
    cc_nv = 4'd15
  } cond_t;

  typedef struct packed {
    logic c;  // carry out, set means no borrow on subtract
    logic n;
    logic z;
    logic v;
  } flags_t;

endpackage

/* exec_top.sv */
// fixed latency of 3 cycles from insn_valid to res_valid and no back-pressure
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_top import exec_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               insn_valid,
  input  logic [`INSN_W-1:0] insn,
  output logic               res_valid,
  output logic               res_wen,
  output logic [`REG_AW-1:0] res_rd,
  output logic [`DATA_W-1:0] res_data,
  output flags_t             res_flags
);

  logic [`REG_AW-1:0] rd_a_idx;
  logic [`REG_AW-1:0] rd_b_idx;
  logic [`DATA_W-1:0] rd_a_val;
  logic [`DATA_W-1:0] rd_b_val;
  flags_t             cur_flags;

  issue_if iss_bus ();
  wb_if    wb_bus ();

  reg_file u_reg_file (
    .clk, .rst, .rd_a_idx, .rd_b_idx, .rd_a_val, .rd_b_val,
    .flags (cur_flags),
    .wb    (wb_bus.regfile)
  );

  insn_decode u_insn_decode (
    .clk, .rst, .insn_valid, .insn, .rd_a_idx, .rd_b_idx, .rd_a_val, .rd_b_val,
    .flags (cur_flags),
    .iss   (iss_bus.decode)
  );

  alu_execute u_alu_execute (.clk, .rst, .iss(iss_bus.execute), .wb(wb_bus.execute));

  result_commit u_result_commit (
    .clk, .rst, .res_valid, .res_wen, .res_rd, .res_data, .res_flags,
    .wb (wb_bus.commit)
  );

endmodule

/* insn_decode.sv */
// insn is sampled only with insn_valid and must be fully known then
`timescale 1ns/1ps
`include "exec_cfg.svh"

module insn_decode import exec_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               insn_valid,
  input  logic [`INSN_W-1:0] insn,
  output logic [`REG_AW-1:0] rd_a_idx,
  output logic [`REG_AW-1:0] rd_b_idx,
  input  logic [`DATA_W-1:0] rd_a_val,
  input  logic [`DATA_W-1:0] rd_b_val,
  input  flags_t             flags,
  issue_if.decode            iss
);

  op_t                op;
  cond_t              cond;
  logic [`REG_AW-1:0] rd;
  logic [`DATA_W-1:0] imm;

  assign op       = op_t'(insn[`OP_MSB -: 4]);
  assign cond     = cond_t'(insn[`COND_MSB -: 4]);
  assign rd       = insn[`RD_MSB -: `REG_AW];
  assign rd_a_idx = insn[`RA_MSB -: `REG_AW];
  assign rd_b_idx = insn[`RB_MSB -: `REG_AW];

  always_comb begin
    if (op == op_movi) begin
      // 16-bit value overlaps rb and imm12
      imm = {{(`DATA_W - `RB_MSB - 1){insn[`RB_MSB]}}, insn[`RB_MSB:0]};
    end else begin
      imm = {{(`DATA_W - `IMM_W){insn[`IMM_W-1]}}, insn[`IMM_W-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      iss.valid <= 1'b0;
    end else begin
      iss.valid <= insn_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (insn_valid) begin
      iss.op    <= op;
      iss.cond  <= cond;
      iss.rd    <= rd;
      iss.ra    <= rd_a_idx;
      iss.rb    <= rd_b_idx;
      iss.a_val <= rd_a_val;   // may be stale, execute forwards
      iss.b_val <= rd_b_val;
      iss.imm   <= imm;
      iss.flags <= flags;
    end
  end

  a_insn_known: assert property (@(posedge clk) disable iff (rst)
    insn_valid |-> !$isunknown(insn));

endmodule

/* issue_if.sv */
// decoded instruction with operands and flags as read in the decode cycle
`timescale 1ns/1ps
`include "exec_cfg.svh"

interface issue_if import exec_pkg::*; ();

  logic               valid;  // one pulse per instruction
  op_t                op;
  cond_t              cond;
  logic [`REG_AW-1:0] rd;
  logic [`REG_AW-1:0] ra;
  logic [`REG_AW-1:0] rb;
  logic [`DATA_W-1:0] a_val;
  logic [`DATA_W-1:0] b_val;
  logic [`DATA_W-1:0] imm;    // already sign extended
  flags_t             flags;

  modport decode (
    output valid, op, cond, rd, ra, rb, a_val, b_val, imm, flags
  );

  modport execute (
    input valid, op, cond, rd, ra, rb, a_val, b_val, imm, flags
  );

endinterface

/* reg_file.sv */
// register 0 is an ordinary register and a write in progress shows through on every read
`timescale 1ns/1ps
`include "exec_cfg.svh"

module reg_file import exec_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic [`REG_AW-1:0] rd_a_idx,
  input  logic [`REG_AW-1:0] rd_b_idx,
  output logic [`DATA_W-1:0] rd_a_val,
  output logic [`DATA_W-1:0] rd_b_val,
  output flags_t             flags,
  wb_if.regfile              wb
);

  logic [`DATA_W-1:0] regs [`REG_CNT];
  flags_t             flags_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_CNT; i++) begin
        regs[i] <= '0;
      end
      flags_q <= '0;
    end else begin
      if (wb.wr_en) begin
        regs[wb.wr_rd] <= wb.wr_data;
      end
      if (wb.wr_flags_en) begin
        flags_q <= wb.wr_flags;
      end
    end
  end

  // write-through
  always_comb begin
    if (wb.wr_en && wb.wr_rd == rd_a_idx) begin
      rd_a_val = wb.wr_data;
    end else begin
      rd_a_val = regs[rd_a_idx];
    end

    if (wb.wr_en && wb.wr_rd == rd_b_idx) begin
      rd_b_val = wb.wr_data;
    end else begin
      rd_b_val = regs[rd_b_idx];
    end

    flags = wb.wr_flags_en ? wb.wr_flags : flags_q;
  end

endmodule

/* result_commit.sv */
// the register file is written at the end of the cycle in which res_valid is high
`timescale 1ns/1ps
`include "exec_cfg.svh"

module result_commit import exec_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  wb_if.commit               wb,
  output logic               res_valid,
  output logic               res_wen,
  output logic [`REG_AW-1:0] res_rd,
  output logic [`DATA_W-1:0] res_data,
  output flags_t             res_flags
);

  logic fwen_q;  // flags write kept off the top ports

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      res_wen   <= 1'b0;
      fwen_q    <= 1'b0;
    end else begin
      res_valid <= wb.valid;
      res_wen   <= wb.wen;
      fwen_q    <= wb.fwen;
    end
  end

  always_ff @(posedge clk) begin
    if (wb.valid) begin
      res_rd    <= wb.rd;
      res_data  <= wb.data;
      res_flags <= wb.flags;
    end
  end

  // writeback side
  assign wb.wr_en       = res_wen;
  assign wb.wr_flags_en = fwen_q;
  assign wb.wr_rd       = res_rd;
  assign wb.wr_data     = res_data;
  assign wb.wr_flags    = res_flags;

  a_wen_valid: assert property (@(posedge clk) disable iff (rst)
    res_wen |-> res_valid);

endmodule

/* sources.f */
+incdir+.
exec_pkg.sv
issue_if.sv
wb_if.sv
reg_file.sv
insn_decode.sv
alu_execute.sv
result_commit.sv
exec_top.sv
tb_exec_top.sv

/* tb_exec_top.sv */
// register 15 is scratch for 32-bit loads and skipped results are checked on wen and flags only
`timescale 1ns/1ps
`include "exec_cfg.svh"

module tb_exec_top import exec_pkg::*; ();

  localparam int clk_period = 8;
  localparam int insn_count = 600;  // upper bound over all tests
  localparam int margin     = 200;  // cycles for reset, gaps and drains

  typedef struct packed {
    logic               wen;
    logic [`REG_AW-1:0] rd;
    logic [`DATA_W-1:0] data;
    flags_t             flags;
    logic [31:0]        due;
  } exp_t;

  logic               clk = 1'b0;
  logic               rst;
  logic               insn_valid;
  logic [`INSN_W-1:0] insn;
  logic               res_valid;
  logic               res_wen;
  logic [`REG_AW-1:0] res_rd;
  logic [`DATA_W-1:0] res_data;
  flags_t             res_flags;

  logic [`DATA_W-1:0] mregs [`REG_CNT];  // reference model state
  flags_t             mflags;
  exp_t               exp_q [$];
  logic [31:0]        cyc = '0;
  logic [31:0]        lfsr = 32'h28d2_004a;
  string              cur_test = "none";
  int                 errors = 0;
  int                 tests_ok = 0;
  int                 tests_bad = 0;

  exec_top UUT (.*);

  always #(clk_period / 2) clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] enc(op_t op, cond_t cc, logic [3:0] rd, logic [3:0] ra,
                                      logic [3:0] rb, logic [11:0] imm);
    return {op, cc, rd, ra, rb, imm};
  endfunction

  function automatic logic [31:0] enc_movi(logic [3:0] rd, logic [15:0] imm);
    return {op_movi, cc_al, rd, 4'd0, imm};
  endfunction

  // odd codes are the inverse of the even code below them
  function automatic logic cond_holds(logic [3:0] cc, flags_t f);
    logic base;
    case (cc[3:1])
      3'd0: base = f.z;
      3'd1: base = f.c;
      3'd2: base = f.n;
      3'd3: base = f.v;
      3'd4: base = f.c && !f.z;
      3'd5: base = f.n == f.v;
      3'd6: base = !f.z && (f.n == f.v);
      default: base = 1'b1;
    endcase
    return base ^ cc[0];
  endfunction

  task automatic model_step(input logic [31:0] w, output exp_t e);
    op_t         op;
    logic [31:0] a, b, y, r;
    logic [32:0] s;
    logic        c, v, arith, ok;
    flags_t      nf;
    op = op_t'(w[31:28]);
    a = mregs[w[19:16]];
    b = mregs[w[15:12]];
    c = 1'b0;
    v = 1'b0;
    arith = 1'b0;
    case (op)
      op_add, op_addi: begin
        y = (op == op_addi) ? {{20{w[11]}}, w[11:0]} : b;
        r = a + y;
        s = {a[31], a} + {y[31], y};  // sign extended sum
        c = (r < a);                  // wrapped past the top
        v = s[32] != s[31];
        arith = 1'b1;
      end
      op_sub, op_cmp: begin
        r = a - b;
        c = (a >= b);  // no borrow
        v = (a[31] != b[31]) && (r[31] != a[31]);
        arith = 1'b1;
      end
      op_and:   r = a & b;
      op_or:    r = a | b;
      op_xor:   r = a ^ b;
      op_shl:   r = a << w[4:0];
      op_shr:   r = a >> w[4:0];
      op_sar:   r = $signed(a) >>> w[4:0];
      op_movi:  r = {{16{w[15]}}, w[15:0]};
      op_sxtb:  r = {{24{a[7]}}, a[7:0]};
      op_sxth:  r = {{16{a[15]}}, a[15:0]};
      op_bswap: r = {a[7:0], a[15:8], a[23:16], a[31:24]};
      default:  r = a;
    endcase
    ok = cond_holds(w[27:24], mflags) && op != op_nop_e && op != op_nop_f;
    nf = mflags;
    if (ok) begin
      nf.n = r[31];
      nf.z = (r == '0);
      if (arith) begin
        nf.c = c;
        nf.v = v;
      end
    end
    mflags = nf;
    e.wen = ok && op != op_cmp;
    if (e.wen) mregs[w[23:20]] = r;
    e.rd = w[23:20];
    e.data = r;
    e.flags = nf;
    e.due = '0;
  endtask

  task automatic issue(input logic [31:0] w);
    exp_t e;
    @(posedge clk);
    insn_valid <= 1'b1;
    insn <= w;
    model_step(w, e);
    e.due = cyc + 32'd4;  // cyc still holds the count before this edge
    exp_q.push_back(e);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      insn_valid <= 1'b0;
    end
  endtask

  task automatic load32(input logic [3:0] rd, input logic [31:0] val);
    issue(enc_movi(rd, val[31:16]));
    issue(enc(op_shl, cc_al, rd, rd, 4'd0, 12'd16));
    issue(enc_movi(4'd15, val[15:0]));
    issue(enc(op_shl, cc_al, 4'd15, 4'd15, 4'd0, 12'd16));
    issue(enc(op_shr, cc_al, 4'd15, 4'd15, 4'd0, 12'd16));  // zero extend low half
    issue(enc(op_or, cc_al, rd, rd, 4'd15, 12'd0));
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expv,
                                 input logic [31:0] act);
    $display("mismatch %s %s: expected %h, actual %h", cur_test, what, expv, act);
    errors++;
  endtask

  task automatic check_result(input exp_t e);
    assert (res_wen === e.wen) else report_mismatch("res_wen", 32'(e.wen), 32'(res_wen));
    if (e.wen) begin
      assert (res_rd === e.rd) else report_mismatch("res_rd", 32'(e.rd), 32'(res_rd));
      assert (res_data === e.data) else report_mismatch("res_data", e.data, res_data);
    end
    assert (res_flags === e.flags)
      else report_mismatch("res_flags", 32'(e.flags), 32'(res_flags));
    assert (cyc == e.due) else begin
      $display("error: %s result came at cycle %0d instead of %0d", cur_test, cyc, e.due);
      errors++;
    end
  endtask

  // outputs settle after the rising edge
  always @(negedge clk) begin
    if (!rst) begin
      if (res_valid) begin
        assert (exp_q.size() > 0) else begin
          $display("error: %s gave a result with nothing in flight", cur_test);
          errors++;
        end
        if (exp_q.size() > 0) check_result(exp_q.pop_front());
      end else if (exp_q.size() > 0) begin
        assert (exp_q[0].due > cyc) else begin
          $display("error: %s result missing 3 cycles after issue", cur_test);
          errors++;
          exp_q.delete(0);
        end
      end
    end
  end

  task automatic finish_test(input int err_before);
    idle_cycles(6);
    assert (exp_q.size() == 0) else begin
      $display("error: %s left %0d results unreported", cur_test, exp_q.size());
      errors++;
      exp_q.delete();
    end
    if (errors == err_before) begin
      $display("test %s: pass", cur_test);
      tests_ok++;
    end else begin
      $display("test %s: fail, %0d errors", cur_test, errors - err_before);
      tests_bad++;
    end
  endtask

  task automatic reset_and_zero();
    int e0;
    e0 = errors;
    cur_test = "reset";
    repeat (4) begin
      @(negedge clk);
      assert (!res_valid) else begin
        $display("error: res_valid high before the first instruction");
        errors++;
      end
    end
    for (int i = 0; i < 16; i++) issue(enc(op_add, cc_al, 4'(i), 4'(i), 4'd0, 12'd0));
    finish_test(e0);
  endtask

  task automatic arith_flags();
    int e0;
    e0 = errors;
    cur_test = "arith";
    for (int i = 0; i < 4; i++) begin
      load32(4'd1, rand_bits(32));
      load32(4'd2, rand_bits(32));
      issue(enc(op_add, cc_al, 4'd3, 4'd1, 4'd2, 12'd0));
      issue(enc(op_sub, cc_al, 4'd4, 4'd1, 4'd2, 12'd0));
      issue(enc(op_addi, cc_al, 4'd5, 4'd1, 4'd0, 12'(rand_bits(12))));
      issue(enc(op_cmp, cc_al, 4'd6, 4'd1, 4'd2, 12'd0));
    end
    load32(4'd1, 32'h7fff_ffff);
    issue(enc_movi(4'd2, 16'd1));
    issue(enc(op_add, cc_al, 4'd3, 4'd1, 4'd2, 12'd0));  // signed overflow
    issue(enc_movi(4'd1, 16'd0));
    issue(enc(op_sub, cc_al, 4'd4, 4'd1, 4'd2, 12'd0));  // 0 - 1 borrows
    issue(enc(op_cmp, cc_al, 4'd6, 4'd2, 4'd2, 12'd0));
    issue(enc(op_cmp, cc_al, 4'd6, 4'd4, 4'd4, 12'd0));
    finish_test(e0);
  endtask

  task automatic logic_and_shifts();
    int         e0;
    logic [4:0] amt;
    e0 = errors;
    cur_test = "logic_shift";
    issue(enc_movi(4'd6, 16'd1));
    issue(enc(op_shl, cc_al, 4'd6, 4'd6, 4'd0, 12'd31));
    issue(enc_movi(4'd7, 16'd1));
    issue(enc(op_cmp, cc_al, 4'd0, 4'd6, 4'd7, 12'd0));  // leaves c and v set
    for (int i = 0; i < 4; i++) begin
      load32(4'd1, rand_bits(32));
      load32(4'd2, rand_bits(32));
      issue(enc(op_and, cc_al, 4'd3, 4'd1, 4'd2, 12'd0));
      issue(enc(op_or, cc_al, 4'd4, 4'd1, 4'd2, 12'd0));
      issue(enc(op_xor, cc_al, 4'd5, 4'd1, 4'd2, 12'd0));
      for (int k = 0; k < 4; k++) begin
        case (k)
          0: amt = 5'd0;
          1: amt = 5'd1;
          2: amt = 5'd31;
          default: amt = 5'(rand_bits(5));
        endcase
        issue(enc(op_shl, cc_al, 4'd8, 4'd1, 4'd0, {7'd0, amt}));
        issue(enc(op_shr, cc_al, 4'd9, 4'd1, 4'd0, {7'd0, amt}));
        issue(enc(op_sar, cc_al, 4'd10, 4'd1, 4'd0, {7'd0, amt}));
      end
    end
    finish_test(e0);
  endtask

  task automatic extend_and_swap();
    int e0;
    e0 = errors;
    cur_test = "extend";
    for (int i = 0; i < 6; i++) begin
      load32(4'd1, rand_bits(32));
      issue(enc(op_sxtb, cc_al, 4'd2, 4'd1, 4'd0, 12'd0));
      issue(enc(op_sxth, cc_al, 4'd3, 4'd1, 4'd0, 12'd0));
      issue(enc(op_bswap, cc_al, 4'd4, 4'd1, 4'd0, 12'd0));
    end
    finish_test(e0);
  endtask

  task automatic predicated_add();
    int          e0;
    logic [31:0] x, y;
    e0 = errors;
    cur_test = "predication";
    for (int p = 0; p < 5; p++) begin
      case (p)
        0: begin  // z and c
          x = 32'd5;
          y = 32'd5;
        end
        1: begin  // n with borrow
          x = 32'd1;
          y = 32'd2;
        end
        2: begin  // c only
          x = 32'd2;
          y = 32'd1;
        end
        3: begin  // c and v
          x = 32'h8000_0000;
          y = 32'd1;
        end
        default: begin  // n and v
          x = 32'h7fff_ffff;
          y = 32'hffff_ffff;
        end
      endcase
      load32(4'(1 + 2 * p), x);
      load32(4'(2 + 2 * p), y);
    end
    load32(4'd12, rand_bits(32));
    load32(4'd13, rand_bits(32));
    for (int p = 0; p < 5; p++) begin
      for (int cc = 0; cc < 16; cc++) begin
        issue(enc(op_cmp, cc_al, 4'd0, 4'(1 + 2 * p), 4'(2 + 2 * p), 12'd0));
        issue(enc(op_add, cond_t'(4'(cc)), 4'd11, 4'd12, 4'd13, 12'd0));
      end
    end
    issue(enc(op_nop_e, cc_al, 4'd1, 4'd2, 4'd3, 12'd0));
    issue(enc(op_nop_f, cc_al, 4'd1, 4'd2, 4'd3, 12'd0));
    finish_test(e0);
  endtask

  task automatic dependency_chain();
    int         e0;
    logic [3:0] prev, rd;
    cond_t      cc;
    e0 = errors;
    cur_test = "dependency";
    prev = 4'd1;
    for (int i = 0; i < 20; i++) begin
      cc = rand_bits(1) ? cond_t'(4'(rand_bits(4))) : cc_al;  // mostly executed
      rd = 4'(rand_bits(4));
      issue(enc(op_t'(4'(rand_bits(4))), cc, rd, prev, 4'(rand_bits(4)),
                12'(rand_bits(12))));
      prev = rd;
      idle_cycles(int'(rand_bits(2)));
    end
    finish_test(e0);
  endtask

  initial begin
    #(insn_count * clk_period + margin * clk_period);
    $display("error: watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst = 1'b1;
    insn_valid = 1'b0;
    insn = '0;
    mflags = '0;
    for (int i = 0; i < `REG_CNT; i++) mregs[i] = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    reset_and_zero();
    arith_flags();
    logic_and_shifts();
    extend_and_swap();
    predicated_add();
    dependency_chain();
    $display("tests passed %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* wb_if.sv */
// one bus for both hops, execute to commit and commit back to the register file
`timescale 1ns/1ps
`include "exec_cfg.svh"

interface wb_if import exec_pkg::*; ();

  // execute register
  logic               valid;
  logic               wen;   // rd written
  logic               fwen;  // flags written
  logic [`REG_AW-1:0] rd;
  logic [`DATA_W-1:0] data;
  flags_t             flags;

  // result register, also the forwarding source
  logic               wr_en;
  logic               wr_flags_en;
  logic [`REG_AW-1:0] wr_rd;
  logic [`DATA_W-1:0] wr_data;
  flags_t             wr_flags;

  modport execute (
    output valid, wen, fwen, rd, data, flags,
    input  wr_en, wr_flags_en, wr_rd, wr_data, wr_flags
  );

  modport commit (
    input  valid, wen, fwen, rd, data, flags,
    output wr_en, wr_flags_en, wr_rd, wr_data, wr_flags
  );

  modport regfile (input wr_en, wr_flags_en, wr_rd, wr_data, wr_flags);

endinterface
